/* common/local_mem_consts.svh */
/* Width, burst limit, memory depth and timing stage constants
   shared by the local memory shim */

`ifndef LOCAL_MEM_CONSTS_SVH
`define LOCAL_MEM_CONSTS_SVH

// Word address and data beat widths
`define LM_ADDR_W 10
`define LM_DATA_W 32

// Transaction ID width, returned unchanged with every response
`define LM_ID_W 4

// AFU burst length field holds beats minus one, so up to 16 beats
`define LM_AFU_LEN_W 4

// Largest burst the memory side accepts
`define LM_FIU_MAX_BEATS 4

// Number of words in the local memory array
`define LM_MEM_DEPTH 1024

// Default number of timing register stages in front of the memory
`define LM_SUGGESTED_REG_STAGES 2

`endif

/* common/local_mem_pkg.sv */
/* Types for the local memory shim: vector typedefs for addresses,
   data, IDs and lengths, the operation enum and the decode FSM states */

`include "local_mem_consts.svh"

package local_mem_pkg;

    // One word address into the local memory
    typedef logic [`LM_ADDR_W-1:0] lm_addr_t;

    // One data beat
    typedef logic [`LM_DATA_W-1:0] lm_data_t;

    // Request ID as issued by the AFU
    typedef logic [`LM_ID_W-1:0] lm_id_t;

    // Burst length in beats minus one
    typedef logic [`LM_AFU_LEN_W-1:0] lm_len_t;

    // Operation carried on the shared command channel
    typedef enum logic {
        LM_OP_READ,
        LM_OP_WRITE
    } lm_op_e;

    // Burst splitter FSM
    typedef enum logic {
        DEC_IDLE,
        DEC_SPLIT
    } dec_state_e;

endpackage

/* hw/burst_decode.sv */
/* Burst splitter: accepts AFU burst commands and issues memory-side
   chunk commands of at most LM_FIU_MAX_BEATS beats with no-reply flags */

`timescale 1ns/1ps
`include "local_mem_consts.svh"

module burst_decode
    import local_mem_pkg::*;
(
    input  logic       axi_afu_if,
    input  logic       rst_n,

    // AFU command channel
    input  logic       cmd_valid,
    input  lm_op_e     cmd_op,
    input  lm_addr_t   cmd_addr,
    input  lm_len_t    cmd_len,
    input  lm_id_t     cmd_id,
    output logic       cmd_ready,

    // Chunk channel toward the memory side
    output logic       chk_valid,
    output lm_op_e     chk_op,
    output lm_addr_t   chk_addr,
    output logic [2:0] chk_beats,
    output lm_id_t     chk_id,
    output logic       chk_no_reply,
    input  logic       chk_ready
);

    // Remaining beat count needs one bit more than the length field
    localparam int REM_W = `LM_AFU_LEN_W + 1;
    localparam logic [REM_W-1:0] MAX_BEATS = REM_W'(`LM_FIU_MAX_BEATS);

    dec_state_e       state;
    logic             boot_done;
    logic [REM_W-1:0] rem_beats;
    lm_op_e           cur_op;
    lm_addr_t         cur_addr;
    lm_id_t           cur_id;
    logic             cmd_fire;
    logic             chk_fire;
    logic             last_chunk;

    // Commands are taken only in idle, and never in the first cycle out of reset
    assign cmd_ready = boot_done && (state == DEC_IDLE);
    assign cmd_fire  = cmd_valid && cmd_ready;

    // A chunk is offered for as long as the burst is being split
    assign chk_valid = (state == DEC_SPLIT);
    assign chk_fire  = chk_valid && chk_ready;

    // The final chunk is whatever is left once it fits in one memory burst
    assign last_chunk   = (rem_beats <= MAX_BEATS);
    assign chk_beats    = last_chunk ? rem_beats[2:0] : MAX_BEATS[2:0];
    assign chk_no_reply = !last_chunk;
    assign chk_op       = cur_op;
    assign chk_addr     = cur_addr;
    assign chk_id       = cur_id;

    // FSM and beat counter
    always_ff @(posedge axi_afu_if)
    begin
        if (!rst_n)
        begin
            state     <= DEC_IDLE;
            boot_done <= 1'b0;
            rem_beats <= '0;
        end
        else
        begin
            boot_done <= 1'b1;
            if (cmd_fire)
            begin
                state     <= DEC_SPLIT;
                rem_beats <= REM_W'(cmd_len) + REM_W'(1);
            end
            else if (chk_fire)
            begin
                rem_beats <= rem_beats - REM_W'(chk_beats);
                // Going idle here lets cmd_ready rise on the next cycle
                if (last_chunk)
                    state <= DEC_IDLE;
            end
        end
    end

    // Latched command fields; the address walks forward one chunk at a time
    always_ff @(posedge axi_afu_if)
    begin
        if (cmd_fire)
        begin
            cur_op   <= cmd_op;
            cur_addr <= cmd_addr;
            cur_id   <= cmd_id;
        end
        else if (chk_fire)
        begin
            cur_addr <= cur_addr + lm_addr_t'(chk_beats);
        end
    end

endmodule

/* hw/mem_exec.sv */
/* Memory side of the shim: timing register stages for chunk commands,
   the local memory array and beat-by-beat read and write execution */

`timescale 1ns/1ps
`include "local_mem_consts.svh"

module mem_exec
    import local_mem_pkg::*;
#(
    parameter int N_REG_STAGES = `LM_SUGGESTED_REG_STAGES
)
(
    input  logic       axi_afu_if,
    input  logic       rst_n,

    // Chunk channel from the burst splitter
    input  logic       chk_valid,
    input  lm_op_e     chk_op,
    input  lm_addr_t   chk_addr,
    input  logic [2:0] chk_beats,
    input  lm_id_t     chk_id,
    input  logic       chk_no_reply,
    output logic       chk_ready,

    // AFU write data
    input  logic       wvalid,
    input  lm_data_t   wdata,
    output logic       wready,

    // Result channel toward the response merger
    output logic       res_valid,
    output lm_op_e     res_op,
    output lm_data_t   res_data,
    output lm_id_t     res_id,
    output logic       res_last,
    output logic       res_no_reply,
    input  logic       res_ready
);

    // At least one stage is always built
    localparam int N_STG = (N_REG_STAGES < 1) ? 1 : N_REG_STAGES;

    logic [N_STG-1:0] stg_valid;
    lm_op_e           stg_op       [N_STG];
    lm_addr_t         stg_addr     [N_STG];
    logic [2:0]       stg_beats    [N_STG];
    lm_id_t           stg_id       [N_STG];
    logic             stg_no_reply [N_STG];

    logic             ex_active;
    lm_op_e           ex_op;
    lm_addr_t         ex_addr;
    logic [2:0]       ex_left;
    lm_id_t           ex_id;
    logic             ex_no_reply;

    logic             pipe_adv;
    logic             ex_take;
    logic             out_free;
    logic             last_beat;
    logic             beat_fire;
    logic             res_push;

    lm_data_t         mem [`LM_MEM_DEPTH];

    // The result register can take a new beat when empty or being drained
    assign out_free  = !res_valid || res_ready;
    assign last_beat = (ex_left == 3'd1);

    // Middle write beats need no result slot, only the closing beat reports
    assign wready    = ex_active && (ex_op == LM_OP_WRITE) && (!last_beat || out_free);

    // Reads advance whenever the result slot is free
    assign beat_fire = ex_active && ((ex_op == LM_OP_READ) ? out_free : (wvalid && wready));
    assign res_push  = beat_fire && ((ex_op == LM_OP_READ) || last_beat);

    // The next chunk enters execution as soon as the current one finishes
    assign ex_take   = stg_valid[N_STG-1] && (!ex_active || (beat_fire && last_beat));

    // All stages shift together, so a full tail stalls the whole pipeline
    assign pipe_adv  = !stg_valid[N_STG-1] || ex_take;
    assign chk_ready = pipe_adv;

    always_ff @(posedge axi_afu_if)
    begin
        if (!rst_n)
        begin
            stg_valid <= '0;
            ex_active <= 1'b0;
            res_valid <= 1'b0;
        end
        else
        begin
            if (pipe_adv)
            begin
                stg_valid[0] <= chk_valid;
                for (int i = 1; i < N_STG; i++)
                    stg_valid[i] <= stg_valid[i-1];
            end

            if (ex_take)
                ex_active <= 1'b1;
            else if (beat_fire && last_beat)
                ex_active <= 1'b0;

            if (res_push)
                res_valid <= 1'b1;
            else if (res_ready)
                res_valid <= 1'b0;
        end
    end

    // Stage payload, execution context and result payload
    always_ff @(posedge axi_afu_if)
    begin
        if (pipe_adv)
        begin
            stg_op[0]       <= chk_op;
            stg_addr[0]     <= chk_addr;
            stg_beats[0]    <= chk_beats;
            stg_id[0]       <= chk_id;
            stg_no_reply[0] <= chk_no_reply;
            for (int i = 1; i < N_STG; i++)
            begin
                stg_op[i]       <= stg_op[i-1];
                stg_addr[i]     <= stg_addr[i-1];
                stg_beats[i]    <= stg_beats[i-1];
                stg_id[i]       <= stg_id[i-1];
                stg_no_reply[i] <= stg_no_reply[i-1];
            end
        end

        if (ex_take)
        begin
            ex_op       <= stg_op[N_STG-1];
            ex_addr     <= stg_addr[N_STG-1];
            ex_left     <= stg_beats[N_STG-1];
            ex_id       <= stg_id[N_STG-1];
            ex_no_reply <= stg_no_reply[N_STG-1];
        end
        else if (beat_fire)
        begin
            ex_addr <= ex_addr + lm_addr_t'(1);
            ex_left <= ex_left - 3'd1;
        end

        // Write results carry stale array data, which the merger ignores
        if (res_push)
        begin
            res_op       <= ex_op;
            res_data     <= mem[ex_addr];
            res_id       <= ex_id;
            res_last     <= last_beat;
            res_no_reply <= ex_no_reply;
        end
    end

    // Local memory array, one write beat per cycle
    always_ff @(posedge axi_afu_if)
    begin
        if (beat_fire && (ex_op == LM_OP_WRITE))
            mem[ex_addr] <= wdata;
    end

endmodule

/* hw/resp_merge.sv */
/* Response merger: turns per-chunk results into AFU read beats and
   a single write response per AFU burst */

`timescale 1ns/1ps
`include "local_mem_consts.svh"

module resp_merge
    import local_mem_pkg::*;
(
    input  logic     axi_afu_if,
    input  logic     rst_n,

    // Result channel from the memory side
    input  logic     res_valid,
    input  lm_op_e   res_op,
    input  lm_data_t res_data,
    input  lm_id_t   res_id,
    input  logic     res_last,
    input  logic     res_no_reply,
    output logic     res_ready,

    // AFU read response
    output logic     rvalid,
    output lm_data_t rdata,
    output lm_id_t   rid,
    output logic     rlast,
    input  logic     rready,

    // AFU write response
    output logic     bvalid,
    output lm_id_t   bid,
    input  logic     bready
);

    logic rd_fire;
    logic wr_fire;

    // No-reply write results are always consumed since they produce nothing
    assign res_ready = (res_op == LM_OP_READ) ? (!rvalid || rready) :
                       (res_no_reply || !bvalid || bready);

    assign rd_fire = res_valid && res_ready && (res_op == LM_OP_READ);
    assign wr_fire = res_valid && res_ready && (res_op == LM_OP_WRITE) && !res_no_reply;

    // Output valids are held until the AFU takes them
    always_ff @(posedge axi_afu_if)
    begin
        if (!rst_n)
        begin
            rvalid <= 1'b0;
            bvalid <= 1'b0;
        end
        else
        begin
            if (rd_fire)
                rvalid <= 1'b1;
            else if (rready)
                rvalid <= 1'b0;

            if (wr_fire)
                bvalid <= 1'b1;
            else if (bready)
                bvalid <= 1'b0;
        end
    end

    // Only the last chunk of a burst may close it on the AFU side
    always_ff @(posedge axi_afu_if)
    begin
        if (rd_fire)
        begin
            rdata <= res_data;
            rid   <= res_id;
            rlast <= res_last && !res_no_reply;
        end
        if (wr_fire)
            bid <= res_id;
    end

endmodule

/* hw/local_mem_shim_top.sv */
/* Local memory shim top: burst splitter, memory execution
   and response merger wired together */

`timescale 1ns/1ps
`include "local_mem_consts.svh"

module local_mem_shim_top
    import local_mem_pkg::*;
#(
    parameter int N_REG_STAGES = `LM_SUGGESTED_REG_STAGES
)
(
    input  logic     axi_afu_if,
    input  logic     rst_n,

    // AFU command channel
    input  logic     cmd_valid,
    input  lm_op_e   cmd_op,
    input  lm_addr_t cmd_addr,
    input  lm_len_t  cmd_len,
    input  lm_id_t   cmd_id,
    output logic     cmd_ready,

    // AFU write data
    input  logic     wvalid,
    input  lm_data_t wdata,
    output logic     wready,

    // AFU read response
    output logic     rvalid,
    output lm_data_t rdata,
    output lm_id_t   rid,
    output logic     rlast,
    input  logic     rready,

    // AFU write response
    output logic     bvalid,
    output lm_id_t   bid,
    input  logic     bready
);

    // Chunk channel between splitter and memory
    logic       chk_valid;
    lm_op_e     chk_op;
    lm_addr_t   chk_addr;
    logic [2:0] chk_beats;
    lm_id_t     chk_id;
    logic       chk_no_reply;
    logic       chk_ready;

    // Result channel between memory and merger
    logic       res_valid;
    lm_op_e     res_op;
    lm_data_t   res_data;
    lm_id_t     res_id;
    logic       res_last;
    logic       res_no_reply;
    logic       res_ready;

    burst_decode decode_i (
        .axi_afu_if   (axi_afu_if),
        .rst_n        (rst_n),
        .cmd_valid    (cmd_valid),
        .cmd_op       (cmd_op),
        .cmd_addr     (cmd_addr),
        .cmd_len      (cmd_len),
        .cmd_id       (cmd_id),
        .cmd_ready    (cmd_ready),
        .chk_valid    (chk_valid),
        .chk_op       (chk_op),
        .chk_addr     (chk_addr),
        .chk_beats    (chk_beats),
        .chk_id       (chk_id),
        .chk_no_reply (chk_no_reply),
        .chk_ready    (chk_ready)
    );

    mem_exec #(
        .N_REG_STAGES (N_REG_STAGES)
    ) exec_i (
        .axi_afu_if   (axi_afu_if),
        .rst_n        (rst_n),
        .chk_valid    (chk_valid),
        .chk_op       (chk_op),
        .chk_addr     (chk_addr),
        .chk_beats    (chk_beats),
        .chk_id       (chk_id),
        .chk_no_reply (chk_no_reply),
        .chk_ready    (chk_ready),
        .wvalid       (wvalid),
        .wdata        (wdata),
        .wready       (wready),
        .res_valid    (res_valid),
        .res_op       (res_op),
        .res_data     (res_data),
        .res_id       (res_id),
        .res_last     (res_last),
        .res_no_reply (res_no_reply),
        .res_ready    (res_ready)
    );

    resp_merge merge_i (
        .axi_afu_if   (axi_afu_if),
        .rst_n        (rst_n),
        .res_valid    (res_valid),
        .res_op       (res_op),
        .res_data     (res_data),
        .res_id       (res_id),
        .res_last     (res_last),
        .res_no_reply (res_no_reply),
        .res_ready    (res_ready),
        .rvalid       (rvalid),
        .rdata        (rdata),
        .rid          (rid),
        .rlast        (rlast),
        .rready       (rready),
        .bvalid       (bvalid),
        .bid          (bid),
        .bready       (bready)
    );

endmodule

/* tests/local_mem_shim_assertions.sv */
/* Concurrent protocol assertions for the local memory shim,
   attached to the top level with bind */

`timescale 1ns/1ps
`include "local_mem_consts.svh"

module local_mem_shim_assertions
    import local_mem_pkg::*;
(
    input logic     axi_afu_if,
    input logic     rst_n,
    input logic     cmd_valid,
    input logic     cmd_ready,
    input logic     chk_valid,
    input logic     chk_ready,
    input logic     chk_no_reply,
    input logic     rvalid,
    input lm_data_t rdata,
    input lm_id_t   rid,
    input logic     rlast,
    input logic     rready,
    input logic     bvalid,
    input lm_id_t   bid,
    input logic     bready
);

    // A read beat stays offered, unchanged, until rready takes it
    rvalid_held: assert property (@(posedge axi_afu_if) disable iff (!rst_n)
        rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rid) && $stable(rlast))
        else $error("rvalid or its payload changed before the beat was accepted");

    // The write response waits for bready in the same way
    bvalid_held: assert property (@(posedge axi_afu_if) disable iff (!rst_n)
        bvalid && !bready |=> bvalid && $stable(bid))
        else $error("bvalid or bid changed before the response was accepted");

    // An accepted command or a non-final chunk keeps the splitter busy
    // and closed to new commands on the next cycle
    no_cmd_while_split: assert property (@(posedge axi_afu_if) disable iff (!rst_n)
        (cmd_valid && cmd_ready) || (chk_valid && chk_ready && chk_no_reply)
        |=> chk_valid && !cmd_ready)
        else $error("cmd_ready high or no chunk offered while a burst is being split");

    // Once the final chunk is taken the splitter accepts commands again
    ready_after_last: assert property (@(posedge axi_afu_if) disable iff (!rst_n)
        chk_valid && chk_ready && !chk_no_reply |=> cmd_ready)
        else $error("cmd_ready did not return after the last chunk of a burst");

    // A reset cycle leaves every valid output low
    quiet_after_reset: assert property (@(posedge axi_afu_if)
        !rst_n |=> !rvalid && !bvalid && !chk_valid)
        else $error("valid output high right after a reset cycle");

endmodule

bind local_mem_shim_top local_mem_shim_assertions assertions_i (
    .axi_afu_if   (axi_afu_if),
    .rst_n        (rst_n),
    .cmd_valid    (cmd_valid),
    .cmd_ready    (cmd_ready),
    .chk_valid    (chk_valid),
    .chk_ready    (chk_ready),
    .chk_no_reply (chk_no_reply),
    .rvalid       (rvalid),
    .rdata        (rdata),
    .rid          (rid),
    .rlast        (rlast),
    .rready       (rready),
    .bvalid       (bvalid),
    .bid          (bid),
    .bready       (bready)
);

/* tests/local_mem_shim_tb.sv */
/* Testbench for the local memory shim: clock, reset, golden-file stimulus,
   random back-pressure, in-order response checks, watchdog and summary */

`timescale 1ns/1ps
`include "local_mem_consts.svh"

module local_mem_shim_tb
    import local_mem_pkg::*;
();

    localparam int    MAX_TESTS   = 64;
    localparam string GOLDEN_FILE = "tests/local_mem_golden.txt";

    logic     axi_afu_if;
    logic     rst_n;
    logic     cmd_valid;
    lm_op_e   cmd_op;
    lm_addr_t cmd_addr;
    lm_len_t  cmd_len;
    lm_id_t   cmd_id;
    logic     cmd_ready;
    logic     wvalid;
    lm_data_t wdata;
    logic     wready;
    logic     rvalid;
    lm_data_t rdata;
    lm_id_t   rid;
    logic     rlast;
    logic     rready;
    logic     bvalid;
    lm_id_t   bid;
    logic     bready;

    // One golden line per test: op, addr, len, id, seed
    logic [31:0] g_op   [MAX_TESTS];
    logic [31:0] g_addr [MAX_TESTS];
    logic [31:0] g_len  [MAX_TESTS];
    logic [31:0] g_id   [MAX_TESTS];
    logic [31:0] g_seed [MAX_TESTS];

    // Test indices split by direction, each in command order
    int rd_list[$];
    int wr_list[$];

    int          num_tests;
    int          tests_done;
    int          errors;
    bit          loaded;
    int          seed = 32'hf4e934fd;
    logic [31:0] rnd;

    local_mem_shim_top dut_i (
        .axi_afu_if (axi_afu_if),
        .rst_n      (rst_n),
        .cmd_valid  (cmd_valid),
        .cmd_op     (cmd_op),
        .cmd_addr   (cmd_addr),
        .cmd_len    (cmd_len),
        .cmd_id     (cmd_id),
        .cmd_ready  (cmd_ready),
        .wvalid     (wvalid),
        .wdata      (wdata),
        .wready     (wready),
        .rvalid     (rvalid),
        .rdata      (rdata),
        .rid        (rid),
        .rlast      (rlast),
        .rready     (rready),
        .bvalid     (bvalid),
        .bid        (bid),
        .bready     (bready)
    );

    initial axi_afu_if = 1'b0;
    always #2 axi_afu_if = ~axi_afu_if;

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected)
        begin
            $display("mismatch at %0t ns: %s is %h, expected %h", $time, what, actual, expected);
            errors++;
        end
    endtask

    task automatic load_golden();
        int          fd;
        int          n;
        logic [31:0] f_op, f_addr, f_len, f_id, f_seed;
        fd = $fopen(GOLDEN_FILE, "r");
        if (fd == 0)
        begin
            $display("Could not open the golden file %s", GOLDEN_FILE);
            errors++;
        end
        else
        begin
            n = $fscanf(fd, "%h %h %h %h %h", f_op, f_addr, f_len, f_id, f_seed);
            while (n == 5 && num_tests < MAX_TESTS)
            begin
                g_op[num_tests]   = f_op;
                g_addr[num_tests] = f_addr;
                g_len[num_tests]  = f_len;
                g_id[num_tests]   = f_id;
                g_seed[num_tests] = f_seed;
                if (f_op[0])
                    wr_list.push_back(num_tests);
                else
                    rd_list.push_back(num_tests);
                num_tests++;
                n = $fscanf(fd, "%h %h %h %h %h", f_op, f_addr, f_len, f_id, f_seed);
            end
            $fclose(fd);
            if (num_tests == 0)
            begin
                $display("The golden file holds no commands");
                errors++;
            end
        end
    endtask

    // Prints one line for a finished test, marking it failed if errors grew
    task automatic report_test(input int idx, input int err_mark);
        string kind;
        kind = g_op[idx][0] ? "write" : "read";
        if (errors == err_mark)
            $display("Test %0d %s addr %h beats %0d id %h: passed",
                     idx + 1, kind, g_addr[idx][9:0], g_len[idx] + 1, g_id[idx][3:0]);
        else
            $display("Test %0d %s addr %h beats %0d id %h: failed",
                     idx + 1, kind, g_addr[idx][9:0], g_len[idx] + 1, g_id[idx][3:0]);
        tests_done++;
    endtask

    // Commands go out back to back; cmd_ready is stable at the falling edge
    task automatic drive_commands();
        @(posedge axi_afu_if);
        for (int i = 0; i < num_tests; i++)
        begin
            cmd_valid <= 1'b1;
            cmd_op    <= g_op[i][0] ? LM_OP_WRITE : LM_OP_READ;
            cmd_addr  <= lm_addr_t'(g_addr[i]);
            cmd_len   <= lm_len_t'(g_len[i]);
            cmd_id    <= lm_id_t'(g_id[i]);
            @(negedge axi_afu_if);
            while (!cmd_ready)
                @(negedge axi_afu_if);
            @(posedge axi_afu_if);
        end
        cmd_valid <= 1'b0;
    endtask

    // Write beats stream in command order, beat i of a burst is seed+i
    task automatic drive_write_data();
        int idx;
        @(posedge axi_afu_if);
        for (int k = 0; k < wr_list.size(); k++)
        begin
            idx = wr_list[k];
            for (int b = 0; b <= int'(g_len[idx]); b++)
            begin
                wvalid <= 1'b1;
                wdata  <= g_seed[idx] + 32'(b);
                @(negedge axi_afu_if);
                while (!wready)
                    @(negedge axi_afu_if);
                @(posedge axi_afu_if);
            end
        end
        wvalid <= 1'b0;
    endtask

    // Random back-pressure, roughly three cycles in four ready
    initial
    begin : toggle_ready
        forever
        begin
            @(posedge axi_afu_if);
            rnd = $random(seed);
            rready <= (rnd[1:0] != 2'b00);
            bready <= (rnd[3:2] != 2'b00);
        end
    end

    // Read beats are matched against the read tests in command order
    initial
    begin : read_monitor
        int beat;
        int rd_ptr;
        int idx;
        int err_mark;
        beat     = 0;
        rd_ptr   = 0;
        err_mark = 0;
        forever
        begin
            @(negedge axi_afu_if);
            if (rst_n && rvalid && rready)
            begin
                if (rd_ptr >= rd_list.size())
                begin
                    $display("Unexpected read beat at %0t ns with rid %h", $time, rid);
                    errors++;
                end
                else
                begin
                    idx = rd_list[rd_ptr];
                    if (beat == 0)
                        err_mark = errors;
                    check_value(rdata, g_seed[idx] + 32'(beat), "rdata");
                    check_value(32'(rid), g_id[idx], "rid");
                    check_value(32'(rlast), (beat == int'(g_len[idx])) ? 32'd1 : 32'd0, "rlast");
                    if (beat == int'(g_len[idx]))
                    begin
                        report_test(idx, err_mark);
                        beat = 0;
                        rd_ptr++;
                    end
                    else
                        beat++;
                end
            end
        end
    end

    // Exactly one write response per write burst, in command order
    initial
    begin : write_monitor
        int wr_ptr;
        int err_mark;
        wr_ptr = 0;
        forever
        begin
            @(negedge axi_afu_if);
            if (rst_n && bvalid && bready)
            begin
                if (wr_ptr >= wr_list.size())
                begin
                    $display("Unexpected write response at %0t ns with bid %h", $time, bid);
                    errors++;
                end
                else
                begin
                    err_mark = errors;
                    check_value(32'(bid), g_id[wr_list[wr_ptr]], "bid");
                    report_test(wr_list[wr_ptr], err_mark);
                    wr_ptr++;
                end
            end
        end
    end

    // Limit is 16 beats of 20 cycles of 4 ns for every golden line
    initial
    begin : watchdog
        int limit_ns;
        wait (loaded);
        limit_ns = ((num_tests > 0) ? num_tests : 1) * 16 * 20 * 4;
        #(limit_ns);
        $display("Timeout: the tests did not finish within %0d ns", limit_ns);
        $display("Done: errors found");
        $finish;
    end

    initial
    begin
        rst_n      = 1'b0;
        cmd_valid  = 1'b0;
        cmd_op     = LM_OP_READ;
        cmd_addr   = '0;
        cmd_len    = '0;
        cmd_id     = '0;
        wvalid     = 1'b0;
        wdata      = '0;
        rready     = 1'b0;
        bready     = 1'b0;
        errors     = 0;
        tests_done = 0;
        num_tests  = 0;
        load_golden();
        loaded = 1'b1;

        repeat (10) @(posedge axi_afu_if);
        rst_n <= 1'b1;
        @(negedge axi_afu_if);
        check_value(32'(rvalid), 32'd0, "rvalid after reset");
        check_value(32'(bvalid), 32'd0, "bvalid after reset");

        fork
            drive_commands();
            drive_write_data();
        join

        wait (tests_done == num_tests);
        // Quiet tail so that a duplicated beat or response still gets caught
        repeat (40) @(posedge axi_afu_if);

        $display("Summary: %0d of %0d tests finished, %0d errors", tests_done, num_tests, errors);
        if (errors == 0)
            $display("Done: no errors");
        else
            $display("Done: errors found");
        $finish;
    end

endmodule

/* project.f */
+incdir+common
common/local_mem_pkg.sv
hw/burst_decode.sv
hw/mem_exec.sv
hw/resp_merge.sv
hw/local_mem_shim_top.sv
tests/local_mem_shim_assertions.sv
tests/local_mem_shim_tb.sv

/* Makefile */
# Verilator flow for the local memory shim testbench

TOP = local_mem_shim_tb
OBJ = obj_dir

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -sv -f project.f \
		--top-module $(TOP) -Mdir $(OBJ) -o $(TOP)

run: compile
	./$(OBJ)/$(TOP) | tee sim.log
	grep -q "Done: no errors" sim.log

clean:
	rm -rf $(OBJ) sim.log

/* tests/local_mem_golden.txt */
1 010 0 1 a0000000
0 010 0 2 a0000000
1 100 f 3 b0000000
0 100 f 4 b0000000
1 200 5 5 c0000000
0 200 5 6 c0000000
1 300 2 7 d0000000
1 305 7 8 e0000000
0 300 2 9 d0000000
0 305 7 a e0000000
1 010 0 b 11110000
0 010 0 c 11110000
1 3f8 7 d 12340000
0 3f8 7 e 12340000
0 102 3 f b0000002
1 020 9 0 55550000
0 020 9 1 55550000
0 024 2 2 55550004
